//--- flist.f
+incdir+hdl
hdl/axi_pkg.sv
hdl/vmem_ctrl_pkg.sv
hdl/axil_ctrl_regs.sv
hdl/axim_rd_engine.sv
hdl/axim_wr_engine.sv
hdl/vmem_subsystem.sv
tb/axi_mem_model.sv
tb/tb_vmem_subsystem.sv

//--- Makefile
SIM   = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = tb_vmem_subsystem
FLIST = flist.f
LOG   = sim.log

.PHONY: sim clean

# The log decides the result, a missing pass line fails the target
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb/tb_vmem_subsystem.sv
`include "vmem_settings.svh"

module tb_vmem_subsystem;
   import axi_pkg::*;
   import vmem_ctrl_pkg::*;

   localparam int          N_ROWS          = 6;
   localparam int          MEM_WORDS       = 256;
   localparam int          WATCHDOG_CYCLES = 2000 * (N_ROWS + 1); // Register phase gets a share
   localparam logic [31:0] BASE            = 32'h8000_0100;

   // One command per row
   typedef struct packed {
      logic        is_rd;
      logic [31:0] offset;
      logic [31:0] size;   // Bytes
      logic        msk_en;
      logic [3:0]  msk;
   } row_t;

   logic                         clk = 1'b0;
   logic                         rst_n_i;
   logic                         axil_aw_valid_i;
   logic                         axil_aw_ready_o;
   axil_req_t                    axil_req_i;
   logic                         axil_b_valid_o;
   logic                         axil_b_ready_i;
   logic                         axil_ar_valid_i;
   logic [`VMEM_AXIL_ADDR_W-1:0] axil_araddr_i;
   logic                         axil_ar_ready_o;
   logic                         axil_r_valid_o;
   logic [`VMEM_DATA_W-1:0]      axil_rdata_o;
   logic                         axil_r_ready_i;
   logic                         rd_start_i;
   vmem_cmd_t                    rd_cmd_i;
   logic                         rd_done_o;
   vmem_beat_t                   rd_beat_o;
   logic                         rd_valid_o;
   logic                         rd_ready_i;
   logic                         wr_start_i;
   vmem_cmd_t                    wr_cmd_i;
   logic                         wr_msk_en_i;
   logic                         wr_done_o;
   vmem_wbeat_t                  wr_beat_i;
   logic                         wr_valid_i;
   logic                         wr_ready_o;
   axi_ar_t                      m_ar_o;
   logic                         m_ar_valid_o;
   logic                         m_ar_ready_i;
   axi_r_t                       m_r_i;
   logic                         m_r_valid_i;
   logic                         m_r_ready_o;
   axi_aw_t                      m_aw_o;
   logic                         m_aw_valid_o;
   logic                         m_aw_ready_i;
   axi_w_t                       m_w_o;
   logic                         m_w_valid_o;
   logic                         m_w_ready_i;
   logic                         m_b_valid_i;
   logic                         m_b_ready_o;

   row_t        rows [0:N_ROWS-1];
   logic [31:0] exp_mem [0:MEM_WORDS-1]; // Expected DDR contents
   int          rd_done_cnt = 0;
   int          wr_done_cnt = 0;
   integer      seed = 35141;

   always #50 clk = ~clk;

   vmem_subsystem u_dut (.*);

   axi_mem_model u_mem (
      .clk, .rst_n_i,
      .ar_i       (m_ar_o),
      .ar_valid_i (m_ar_valid_o),
      .ar_ready_o (m_ar_ready_i),
      .r_o        (m_r_i),
      .r_valid_o  (m_r_valid_i),
      .r_ready_i  (m_r_ready_o),
      .aw_i       (m_aw_o),
      .aw_valid_i (m_aw_valid_o),
      .aw_ready_o (m_aw_ready_i),
      .w_i        (m_w_o),
      .w_valid_i  (m_w_valid_o),
      .w_ready_o  (m_w_ready_i),
      .b_valid_o  (m_b_valid_i),
      .b_ready_i  (m_b_ready_o)
   );

   always @(posedge clk) begin
      if (rd_done_o) rd_done_cnt <= rd_done_cnt + 1;
      if (wr_done_o) wr_done_cnt <= wr_done_cnt + 1;
   end

   task automatic abort_run();
      $display("STATUS: FAIL");
      $fatal(1, "Simulation stopped on error");
   endtask

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("Mismatch at time %0t: %s, got 0x%08h, expected 0x%08h",
                  $time, what, got, exp);
         abort_run();
      end
   endtask

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
      abort_run();
   end

   task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
      axil_req_i      = '{addr: addr, data: data, strb: strb};
      axil_aw_valid_i = 1'b1;
      @(posedge clk);
      while (!axil_aw_ready_o) @(posedge clk);
      #1 axil_aw_valid_i = 1'b0;
      axil_b_ready_i = 1'b1;
      @(posedge clk);
      while (!axil_b_valid_o) @(posedge clk);
      #1 axil_b_ready_i = 1'b0;
   endtask

   task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
      axil_araddr_i   = addr;
      axil_ar_valid_i = 1'b1;
      @(posedge clk);
      while (!axil_ar_ready_o) @(posedge clk);
      #1 axil_ar_valid_i = 1'b0;
      axil_r_ready_i = 1'b1;
      @(posedge clk);
      while (!axil_r_valid_o) @(posedge clk);
      data = axil_rdata_o;
      #1 axil_r_ready_i = 1'b0;
   endtask

   // One-cycle start pulse on the engine the row selects
   task automatic issue_cmd(input row_t row);
      vmem_cmd_t c;
      c = '{offset: row.offset, size: row.size};
      if (row.is_rd) begin
         rd_cmd_i   = c;
         rd_start_i = 1'b1;
      end else begin
         wr_cmd_i    = c;
         wr_msk_en_i = row.msk_en;
         wr_start_i  = 1'b1;
      end
      @(posedge clk);
      #1;
      rd_start_i = 1'b0;
      wr_start_i = 1'b0;
   endtask

   function automatic logic [31:0] beat_data(input int row, input int k);
      return {4'hB, 4'(row), 8'h5C, 16'(k)};
   endfunction

   task automatic feed_wr_stream(input row_t row, input int rownum);
      int          nbeats;
      int          sent;
      logic [31:0] a;
      logic [3:0]  strb;
      nbeats = int'(row.size >> 2);
      strb   = row.msk_en ? row.msk : 4'hF;
      sent   = 0;
      wr_beat_i  = '{data: beat_data(rownum, 0), msk: row.msk};
      wr_valid_i = 1'b1;
      while (sent < nbeats) begin
         @(posedge clk);
         if (wr_valid_i && wr_ready_o) begin
            a = BASE + row.offset + 32'(4 * sent);
            for (int i = 0; i < 4; i++) begin
               if (strb[i]) exp_mem[a[9:2]][8*i +: 8] = wr_beat_i.data[8*i +: 8];
            end
            sent++;
         end
         #1;
         if (sent < nbeats) wr_beat_i = '{data: beat_data(rownum, sent), msk: row.msk};
         else wr_valid_i = 1'b0;
      end
   endtask

   task automatic sink_rd_stream(input row_t row);
      int          nbeats;
      int          got;
      logic [31:0] a;
      nbeats = int'(row.size >> 2);
      got    = 0;
      while (got < nbeats) begin
         @(posedge clk);
         if (rd_valid_o && rd_ready_i) begin
            a = BASE + row.offset + 32'(4 * got);
            check("read data", rd_beat_o.data, exp_mem[a[9:2]]);
            check("read last flag", 32'(rd_beat_o.last), 32'(got == nbeats - 1));
            got++;
         end
         #1 rd_ready_i = (($random(seed) & 1) != 0); // Random back-pressure
      end
      rd_ready_i = 1'b0;
   endtask

   // Full bursts first, then the remainder, 64 bytes apart
   task automatic check_bursts(input row_t row, input int first);
      int      nbeats;
      int      nb;
      int      left;
      axi_ar_t b;
      nbeats = int'(row.size >> 2);
      nb     = (nbeats + `VMEM_BURST_LEN - 1) / `VMEM_BURST_LEN;
      check("burst count", (row.is_rd ? u_mem.ar_cnt : u_mem.aw_cnt) - first, nb);
      for (int j = 0; j < nb; j++) begin
         b    = row.is_rd ? u_mem.ar_log[6'(first + j)] : u_mem.aw_log[6'(first + j)];
         left = nbeats - `VMEM_BURST_LEN * j;
         check("burst address", b.addr, BASE + row.offset + 32'(64 * j));
         check("burst len", 32'(b.len), (left > `VMEM_BURST_LEN) ? 32'd15 : 32'(left - 1));
      end
   endtask

   task automatic check_memory();
      for (int i = 0; i < MEM_WORDS; i++) begin
         check($sformatf("memory word %0d", i), u_mem.mem[8'(i)], exp_mem[8'(i)]);
      end
   endtask

   initial begin
      logic [31:0] rdata;
      int          rd_goal;
      int          wr_goal;
      int          ar_before;
      int          aw_before;
      rst_n_i         = 1'b0;
      axil_aw_valid_i = 1'b0;
      axil_req_i      = '0;
      axil_b_ready_i  = 1'b0;
      axil_ar_valid_i = 1'b0;
      axil_araddr_i   = '0;
      axil_r_ready_i  = 1'b0;
      rd_start_i      = 1'b0;
      rd_cmd_i        = '0;
      rd_ready_i      = 1'b0;
      wr_start_i      = 1'b0;
      wr_cmd_i        = '0;
      wr_msk_en_i     = 1'b0;
      wr_beat_i       = '0;
      wr_valid_i      = 1'b0;
      //        is_rd  offset     size     msk_en msk
      rows = '{'{1'b0, 32'h020, 32'd100, 1'b0, 4'h0},
               '{1'b0, 32'h024, 32'd8,   1'b1, 4'b0110},
               '{1'b1, 32'h020, 32'd100, 1'b0, 4'h0},
               '{1'b0, 32'h1C0, 32'd64,  1'b1, 4'b1001},
               '{1'b1, 32'h1C0, 32'd64,  1'b0, 4'h0},
               '{1'b1, 32'h024, 32'd4,   1'b0, 4'h0}};
      repeat (4) @(posedge clk);
      #1 rst_n_i = 1'b1;
      for (int i = 0; i < MEM_WORDS; i++) exp_mem[8'(i)] = u_mem.mem[8'(i)];

      axil_write(`VMEM_REG_BASE, BASE, 4'hF);
      axil_read(`VMEM_REG_BASE, rdata);
      check("base register readback", rdata, BASE);
      axil_read(4'hC, rdata);
      check("unmapped register read", rdata, 32'd0);

      // Starts with ce low must be dropped
      rd_cmd_i   = '{offset: 32'h0, size: 32'd16};
      wr_cmd_i   = '{offset: 32'h0, size: 32'd16};
      rd_start_i = 1'b1;
      wr_start_i = 1'b1;
      @(posedge clk);
      #1;
      rd_start_i = 1'b0;
      wr_start_i = 1'b0;
      repeat (50) @(posedge clk);
      #1;
      check("AR bursts with ce off", u_mem.ar_cnt, 0);
      check("AW bursts with ce off", u_mem.aw_cnt, 0);
      check("done pulses with ce off", rd_done_cnt + wr_done_cnt, 0);

      axil_write(`VMEM_REG_CTRL, 32'd1, 4'h1);
      axil_read(`VMEM_REG_CTRL, rdata);
      check("control register readback", rdata, 32'd1);

      for (int r = 0; r < N_ROWS; r++) begin
         ar_before = u_mem.ar_cnt;
         aw_before = u_mem.aw_cnt;
         rd_goal   = rd_done_cnt + int'(rows[r].is_rd);
         wr_goal   = wr_done_cnt + int'(!rows[r].is_rd);
         issue_cmd(rows[r]);
         fork
            if (rows[r].is_rd) sink_rd_stream(rows[r]);
            else feed_wr_stream(rows[r], r);
            begin
               axil_read(`VMEM_REG_STATUS, rdata);
               check("status while busy", rdata, rows[r].is_rd ? 32'd1 : 32'd2);
            end
         join
         wait (rd_done_cnt == rd_goal && wr_done_cnt == wr_goal);
         @(posedge clk);
         #1;
         axil_read(`VMEM_REG_STATUS, rdata);
         check("status after done", rdata, 32'd0);
         check("read done pulses", rd_done_cnt, rd_goal);  // Exactly one pulse
         check("write done pulses", wr_done_cnt, wr_goal);
         check_bursts(rows[r], rows[r].is_rd ? ar_before : aw_before);
         if (!rows[r].is_rd) check_memory();
      end

      $display("STATUS: PASS");
      $finish;
   end

endmodule

//--- tb/axi_mem_model.sv
`include "vmem_settings.svh"

module axi_mem_model (
   input  logic             clk,
   input  logic             rst_n_i,
   input  axi_pkg::axi_ar_t ar_i,
   input  logic             ar_valid_i,
   output logic             ar_ready_o,
   output axi_pkg::axi_r_t  r_o,
   output logic             r_valid_o,
   input  logic             r_ready_i,
   input  axi_pkg::axi_aw_t aw_i,
   input  logic             aw_valid_i,
   output logic             aw_ready_o,
   input  axi_pkg::axi_w_t  w_i,
   input  logic             w_valid_i,
   output logic             w_ready_o,
   output logic             b_valid_o,
   input  logic             b_ready_i
);
   import axi_pkg::*;

   localparam int WORDS = 256;

   logic [31:0] mem [0:WORDS-1];   // Word index is addr[9:2]
   axi_ar_t     ar_log [0:63];     // Every burst seen on AR
   axi_aw_t     aw_log [0:63];
   int          ar_cnt = 0;
   int          aw_cnt = 0;
   integer      seed;
   logic        wr_act;            // W phase of an accepted AW
   logic        b_pend;
   logic        rd_act;
   logic [31:0] wr_addr;
   logic [31:0] rd_addr;
   logic [8:0]  rd_left;           // Beats left in the current read burst

   initial begin
      seed = 35141;
      for (int i = 0; i < WORDS; i++) begin
         mem[i] = 32'h5A00_0000 ^ (32'(i) * 32'h0001_0101);
      end
      {wr_act, b_pend, rd_act} = 3'b000;
      {ar_ready_o, aw_ready_o, w_ready_o, r_valid_o, b_valid_o} = 5'b00000;
      r_o = '0;
      forever begin
         @(posedge clk);
         if (!rst_n_i) begin
            {wr_act, b_pend, rd_act} = 3'b000;
         end else begin
            if (aw_valid_i && aw_ready_o) begin
               aw_log[aw_cnt[5:0]] = aw_i;
               aw_cnt++;
               wr_addr = aw_i.addr;
               wr_act  = 1'b1;
            end
            if (w_valid_i && w_ready_o) begin
               for (int i = 0; i < 4; i++) begin
                  if (w_i.strb[i]) mem[wr_addr[9:2]][8*i +: 8] = w_i.data[8*i +: 8];
               end
               wr_addr = wr_addr + 32'd4;
               if (w_i.last) begin
                  wr_act = 1'b0;
                  b_pend = 1'b1;
               end
            end
            if (b_valid_o && b_ready_i) b_pend = 1'b0; // Response is always OKAY
            if (ar_valid_i && ar_ready_o) begin
               ar_log[ar_cnt[5:0]] = ar_i;
               ar_cnt++;
               rd_addr = ar_i.addr;
               rd_left = {1'b0, ar_i.len} + 9'd1;
               rd_act  = 1'b1;
            end
            if (r_valid_o && r_ready_i) begin
               rd_addr = rd_addr + 32'd4;
               rd_left = rd_left - 9'd1;
               if (rd_left == 9'd0) rd_act = 1'b0;
            end
         end
         #1;
         // Readies stall on about one cycle in four
         aw_ready_o = !wr_act && !b_pend && (($random(seed) & 3) != 0);
         w_ready_o  = wr_act && (($random(seed) & 3) != 0);
         b_valid_o  = b_pend;
         ar_ready_o = !rd_act && (($random(seed) & 3) != 0);
         r_valid_o  = rd_act;
         r_o        = '{data: mem[rd_addr[9:2]], last: (rd_left == 9'd1)};
      end
   end

endmodule

//--- hdl/vmem_subsystem.sv
`include "vmem_settings.svh"

module vmem_subsystem (
   input  logic                         clk,
   input  logic                         rst_n_i,
   // AXI-Lite slave
   input  logic                         axil_aw_valid_i,
   output logic                         axil_aw_ready_o,
   input  axi_pkg::axil_req_t           axil_req_i,
   output logic                         axil_b_valid_o,
   input  logic                         axil_b_ready_i,
   input  logic                         axil_ar_valid_i,
   input  logic [`VMEM_AXIL_ADDR_W-1:0] axil_araddr_i,
   output logic                         axil_ar_ready_o,
   output logic                         axil_r_valid_o,
   output logic [`VMEM_DATA_W-1:0]      axil_rdata_o,
   input  logic                         axil_r_ready_i,
   // Load side of the vector core
   input  logic                         rd_start_i,
   input  vmem_ctrl_pkg::vmem_cmd_t     rd_cmd_i,
   output logic                         rd_done_o,
   output vmem_ctrl_pkg::vmem_beat_t    rd_beat_o,
   output logic                         rd_valid_o,
   input  logic                         rd_ready_i,
   // Store side of the vector core
   input  logic                         wr_start_i,
   input  vmem_ctrl_pkg::vmem_cmd_t     wr_cmd_i,
   input  logic                         wr_msk_en_i,
   output logic                         wr_done_o,
   input  vmem_ctrl_pkg::vmem_wbeat_t   wr_beat_i,
   input  logic                         wr_valid_i,
   output logic                         wr_ready_o,
   // AXI4 master towards DDR
   output axi_pkg::axi_ar_t             m_ar_o,
   output logic                         m_ar_valid_o,
   input  logic                         m_ar_ready_i,
   input  axi_pkg::axi_r_t              m_r_i,
   input  logic                         m_r_valid_i,
   output logic                         m_r_ready_o,
   output axi_pkg::axi_aw_t             m_aw_o,
   output logic                         m_aw_valid_o,
   input  logic                         m_aw_ready_i,
   output axi_pkg::axi_w_t              m_w_o,
   output logic                         m_w_valid_o,
   input  logic                         m_w_ready_i,
   input  logic                         m_b_valid_i,
   output logic                         m_b_ready_o
);

   logic                    ce;        // Processor enable from software
   logic [`VMEM_ADDR_W-1:0] base_addr;
   logic                    rd_busy;
   logic                    wr_busy;

   axil_ctrl_regs u_regs (
      .clk, .rst_n_i,
      .axil_aw_valid_i, .axil_aw_ready_o, .axil_req_i,
      .axil_b_valid_o, .axil_b_ready_i,
      .axil_ar_valid_i, .axil_araddr_i, .axil_ar_ready_o,
      .axil_r_valid_o, .axil_rdata_o, .axil_r_ready_i,
      .rd_busy_i   (rd_busy),
      .wr_busy_i   (wr_busy),
      .ce_o        (ce),
      .base_addr_o (base_addr)
   );

   axim_rd_engine u_rd (
      .clk, .rst_n_i,
      .ce_i        (ce),
      .base_addr_i (base_addr),
      .rd_start_i, .rd_cmd_i, .rd_done_o,
      .rd_busy_o   (rd_busy),
      .ar_o        (m_ar_o),
      .ar_valid_o  (m_ar_valid_o),
      .ar_ready_i  (m_ar_ready_i),
      .r_i         (m_r_i),
      .r_valid_i   (m_r_valid_i),
      .r_ready_o   (m_r_ready_o),
      .rd_beat_o, .rd_valid_o, .rd_ready_i
   );

   axim_wr_engine u_wr (
      .clk, .rst_n_i,
      .ce_i        (ce),
      .base_addr_i (base_addr),
      .wr_start_i, .wr_cmd_i, .wr_msk_en_i, .wr_done_o,
      .wr_busy_o   (wr_busy),
      .aw_o        (m_aw_o),
      .aw_valid_o  (m_aw_valid_o),
      .aw_ready_i  (m_aw_ready_i),
      .w_o         (m_w_o),
      .w_valid_o   (m_w_valid_o),
      .w_ready_i   (m_w_ready_i),
      .b_valid_i   (m_b_valid_i),
      .b_ready_o   (m_b_ready_o),
      .wr_beat_i, .wr_valid_i, .wr_ready_o
   );

endmodule

//--- hdl/axim_wr_engine.sv
`include "vmem_settings.svh"

module axim_wr_engine (
   input  logic                       clk,
   input  logic                       rst_n_i,
   input  logic                       ce_i,
   input  logic [`VMEM_ADDR_W-1:0]    base_addr_i,
   input  logic                       wr_start_i,
   input  vmem_ctrl_pkg::vmem_cmd_t   wr_cmd_i,
   input  logic                       wr_msk_en_i,
   output logic                       wr_done_o,
   output logic                       wr_busy_o,
   output axi_pkg::axi_aw_t           aw_o,
   output logic                       aw_valid_o,
   input  logic                       aw_ready_i,
   output axi_pkg::axi_w_t            w_o,
   output logic                       w_valid_o,
   input  logic                       w_ready_i,
   input  logic                       b_valid_i,
   output logic                       b_ready_o,
   input  vmem_ctrl_pkg::vmem_wbeat_t wr_beat_i,
   input  logic                       wr_valid_i,
   output logic                       wr_ready_o
);
   import axi_pkg::*;

   localparam int BURST_BYTES = `VMEM_BURST_LEN * `VMEM_STRB_W;
   localparam int BEAT_W      = `VMEM_XFER_W - 2;

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_ADDR,
      WR_DATA,
      WR_RESP
   } wr_state_e;

   wr_state_e               state_q;
   logic [`VMEM_ADDR_W-1:0] addr_q;
   logic [BEAT_W-1:0]       beats_q;     // Beats left in the whole transfer
   logic [7:0]              beat_cnt_q;  // Beat index inside the burst
   logic [7:0]              len_q;       // len sent on AW
   logic                    msk_en_q;
   logic                    done_q;
   logic [7:0]              burst_len;
   logic                    accept;
   logic                    aw_fire;
   logic                    w_fire;
   logic                    b_fire;
   logic                    in_data;
   logic                    w_last;

   assign accept  = wr_start_i & ce_i & (state_q == WR_IDLE);
   assign aw_fire = aw_valid_o & aw_ready_i;
   assign w_fire  = w_valid_o & w_ready_i;
   assign b_fire  = b_valid_i & b_ready_o;
   assign in_data = (state_q == WR_DATA);
   assign w_last  = (beat_cnt_q == len_q);

   assign burst_len = (beats_q > BEAT_W'(`VMEM_BURST_LEN)) ?
                      8'(`VMEM_BURST_LEN - 1) : beats_q[7:0] - 8'd1;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= WR_IDLE;
         done_q  <= 1'b0;
      end else begin
         done_q <= 1'b0;
         case (state_q)
            WR_IDLE: if (accept) state_q <= WR_ADDR;
            WR_ADDR: if (aw_fire) state_q <= WR_DATA;
            WR_DATA: if (w_fire && w_last) state_q <= WR_RESP;
            WR_RESP: begin
               // bresp is not checked
               if (b_fire) begin
                  state_q <= (beats_q == '0) ? WR_IDLE : WR_ADDR;
                  done_q  <= (beats_q == '0);
               end
            end
            default: state_q <= WR_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         beats_q    <= '0;
         beat_cnt_q <= '0;
         len_q      <= '0;
         msk_en_q   <= 1'b0;
      end else begin
         if (accept) begin
            beats_q  <= wr_cmd_i.size[`VMEM_XFER_W-1:2];
            msk_en_q <= wr_msk_en_i; // Held for the whole command
         end else if (w_fire) begin
            beats_q <= beats_q - BEAT_W'(1);
         end
         if (aw_fire) begin
            beat_cnt_q <= '0;
            len_q      <= burst_len;
         end else if (w_fire) begin
            beat_cnt_q <= beat_cnt_q + 8'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         addr_q <= base_addr_i + wr_cmd_i.offset;
      end else if (b_fire) begin
         addr_q <= addr_q + `VMEM_ADDR_W'(BURST_BYTES);
      end
   end

   assign aw_valid_o = (state_q == WR_ADDR);
   assign aw_o       = axi_aw_t'{addr: addr_q, len: burst_len};

   assign w_valid_o  = in_data & wr_valid_i;
   assign wr_ready_o = in_data & w_ready_i;
   assign w_o        = axi_w_t'{
      data: wr_beat_i.data,
      strb: msk_en_q ? wr_beat_i.msk : {`VMEM_STRB_W{1'b1}},
      last: w_last
   };

   assign b_ready_o  = (state_q == WR_RESP);
   assign wr_done_o  = done_q;
   assign wr_busy_o  = (state_q != WR_IDLE);

   // wlast from the latched AW len must land on a burst or transfer end
   a_wlast_at_len: assert property (@(posedge clk) disable iff (!rst_n_i)
      w_valid_o && w_o.last |->
         beats_q == BEAT_W'(1) || beat_cnt_q == 8'(`VMEM_BURST_LEN - 1))
      else $error("wlast off the burst boundary");

endmodule

//--- hdl/axim_rd_engine.sv
`include "vmem_settings.svh"

module axim_rd_engine (
   input  logic                      clk,
   input  logic                      rst_n_i,
   input  logic                      ce_i,
   input  logic [`VMEM_ADDR_W-1:0]   base_addr_i,
   input  logic                      rd_start_i,
   input  vmem_ctrl_pkg::vmem_cmd_t  rd_cmd_i,
   output logic                      rd_done_o,
   output logic                      rd_busy_o,
   output axi_pkg::axi_ar_t          ar_o,
   output logic                      ar_valid_o,
   input  logic                      ar_ready_i,
   input  axi_pkg::axi_r_t           r_i,
   input  logic                      r_valid_i,
   output logic                      r_ready_o,
   output vmem_ctrl_pkg::vmem_beat_t rd_beat_o,
   output logic                      rd_valid_o,
   input  logic                      rd_ready_i
);
   import axi_pkg::*;
   import vmem_ctrl_pkg::*;

   localparam int BURST_BYTES = `VMEM_BURST_LEN * `VMEM_STRB_W;
   localparam int BEAT_W      = `VMEM_XFER_W - 2;

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_ADDR,
      RD_DATA
   } rd_state_e;

   rd_state_e               state_q;
   logic [`VMEM_ADDR_W-1:0] addr_q;    // Address of the current burst
   logic [BEAT_W-1:0]       beats_q;   // Beats left in the whole transfer
   logic                    done_q;
   logic [7:0]              burst_len;
   logic                    accept;
   logic                    ar_fire;
   logic                    r_fire;
   logic                    in_data;
   logic                    final_beat;

   assign accept     = rd_start_i & ce_i & (state_q == RD_IDLE);
   assign ar_fire    = ar_valid_o & ar_ready_i;
   assign r_fire     = r_valid_i & r_ready_o;
   assign in_data    = (state_q == RD_DATA);
   assign final_beat = (beats_q == BEAT_W'(1));

   // Full bursts until the remainder fits in one
   assign burst_len = (beats_q > BEAT_W'(`VMEM_BURST_LEN)) ?
                      8'(`VMEM_BURST_LEN - 1) : beats_q[7:0] - 8'd1;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= RD_IDLE;
         done_q  <= 1'b0;
      end else begin
         done_q <= 1'b0;
         case (state_q)
            RD_IDLE: begin
               if (accept) begin
                  state_q <= RD_ADDR;
               end
            end
            RD_ADDR: begin
               if (ar_fire) begin
                  state_q <= RD_DATA;
               end
            end
            RD_DATA: begin
               if (r_fire && r_i.last) begin
                  state_q <= final_beat ? RD_IDLE : RD_ADDR;
                  done_q  <= final_beat;
               end
            end
            default: state_q <= RD_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         beats_q <= '0;
      end else if (accept) begin
         beats_q <= rd_cmd_i.size[`VMEM_XFER_W-1:2];
      end else if (r_fire) begin
         beats_q <= beats_q - BEAT_W'(1);
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         addr_q <= base_addr_i + rd_cmd_i.offset;
      end else if (r_fire && r_i.last) begin
         addr_q <= addr_q + `VMEM_ADDR_W'(BURST_BYTES); // Next 64-byte block
      end
   end

   assign ar_valid_o = (state_q == RD_ADDR);
   assign ar_o       = axi_ar_t'{addr: addr_q, len: burst_len};

   // R beats flow straight to the stream, back-pressure included
   assign r_ready_o  = in_data & rd_ready_i;
   assign rd_valid_o = in_data & r_valid_i;
   assign rd_beat_o  = vmem_beat_t'{data: r_i.data, last: final_beat};

   assign rd_done_o  = done_q;
   assign rd_busy_o  = (state_q != RD_IDLE);

   a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
      ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
      else $error("ar payload changed while stalled");

endmodule

//--- hdl/axil_ctrl_regs.sv
`include "vmem_settings.svh"

module axil_ctrl_regs (
   input  logic                         clk,
   input  logic                         rst_n_i,
   input  logic                         axil_aw_valid_i,
   output logic                         axil_aw_ready_o,
   input  axi_pkg::axil_req_t           axil_req_i,
   output logic                         axil_b_valid_o,
   input  logic                         axil_b_ready_i,
   input  logic                         axil_ar_valid_i,
   input  logic [`VMEM_AXIL_ADDR_W-1:0] axil_araddr_i,
   output logic                         axil_ar_ready_o,
   output logic                         axil_r_valid_o,
   output logic [`VMEM_DATA_W-1:0]      axil_rdata_o,
   input  logic                         axil_r_ready_i,
   input  logic                         rd_busy_i,
   input  logic                         wr_busy_i,
   output logic                         ce_o,
   output logic [`VMEM_ADDR_W-1:0]      base_addr_o
);

   logic                    b_valid_q;
   logic                    r_valid_q;
   logic [`VMEM_DATA_W-1:0] rdata_q;
   logic                    ce_q;
   logic [`VMEM_ADDR_W-1:0] base_q;
   logic                    wr_fire;
   logic                    rd_fire;
   logic [`VMEM_DATA_W-1:0] rd_word;

   // Address and data are taken in the same cycle
   assign axil_aw_ready_o = axil_aw_valid_i & ~b_valid_q;
   assign wr_fire         = axil_aw_valid_i & axil_aw_ready_o;
   assign axil_ar_ready_o = ~r_valid_q; // One read in flight
   assign rd_fire         = axil_ar_valid_i & axil_ar_ready_o;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ce_q   <= 1'b0;
         base_q <= '0;
      end else if (wr_fire) begin
         if (axil_req_i.addr == `VMEM_REG_CTRL && axil_req_i.strb[0]) begin
            ce_q <= axil_req_i.data[0];
         end
         if (axil_req_i.addr == `VMEM_REG_BASE) begin
            for (int i = 0; i < `VMEM_STRB_W; i++) begin
               if (axil_req_i.strb[i]) begin
                  base_q[8*i +: 8] <= axil_req_i.data[8*i +: 8];
               end
            end
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         b_valid_q <= 1'b0;
         r_valid_q <= 1'b0;
      end else begin
         if (wr_fire) begin
            b_valid_q <= 1'b1;
         end else if (axil_b_ready_i) begin
            b_valid_q <= 1'b0;
         end
         if (rd_fire) begin
            r_valid_q <= 1'b1;
         end else if (axil_r_ready_i) begin
            r_valid_q <= 1'b0;
         end
      end
   end

   // Read decode, unmapped offsets give 0
   always_comb begin
      case (axil_araddr_i)
         `VMEM_REG_CTRL:   rd_word = {{(`VMEM_DATA_W-1){1'b0}}, ce_q};
         `VMEM_REG_BASE:   rd_word = base_q;
         `VMEM_REG_STATUS: rd_word = {{(`VMEM_DATA_W-2){1'b0}}, wr_busy_i, rd_busy_i};
         default:          rd_word = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rd_fire) begin
         rdata_q <= rd_word; // Busy bits sampled at the ar transfer
      end
   end

   assign axil_b_valid_o = b_valid_q;
   assign axil_r_valid_o = r_valid_q;
   assign axil_rdata_o   = rdata_q;
   assign ce_o           = ce_q;
   assign base_addr_o    = base_q;

   // A write response is never withdrawn before the host takes it
   a_b_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
      axil_b_valid_o && !axil_b_ready_i |=> axil_b_valid_o)
      else $error("bvalid dropped before bready");

endmodule

//--- hdl/vmem_ctrl_pkg.sv
`include "vmem_settings.svh"

package vmem_ctrl_pkg;

   // Load or store request from the vector core
   typedef struct packed {
      logic [`VMEM_ADDR_W-1:0] offset; // Added to the base address
      logic [`VMEM_XFER_W-1:0] size;   // In bytes, multiple of 4
   } vmem_cmd_t;

   // Load stream towards the core
   typedef struct packed {
      logic [`VMEM_DATA_W-1:0] data;
      logic                    last;   // Final beat of the command
   } vmem_beat_t;

   // Store stream from the core
   typedef struct packed {
      logic [`VMEM_DATA_W-1:0] data;
      logic [`VMEM_STRB_W-1:0] msk;    // Byte mask, used when masking is on
   } vmem_wbeat_t;

endpackage

//--- hdl/axi_pkg.sv
`include "vmem_settings.svh"

package axi_pkg;

   // Read address channel
   typedef struct packed {
      logic [`VMEM_ADDR_W-1:0] addr;
      logic [7:0]              len;  // Beats minus one
   } axi_ar_t;

   // Write address carries the same fields
   typedef axi_ar_t axi_aw_t;

   // Write data channel
   typedef struct packed {
      logic [`VMEM_DATA_W-1:0] data;
      logic [`VMEM_STRB_W-1:0] strb;
      logic                    last;
   } axi_w_t;

   // Read data channel, rresp is not used
   typedef struct packed {
      logic [`VMEM_DATA_W-1:0] data;
      logic                    last;
   } axi_r_t;

   // AXI-Lite write, address and data travel together
   typedef struct packed {
      logic [`VMEM_AXIL_ADDR_W-1:0] addr;
      logic [`VMEM_DATA_W-1:0]      data;
      logic [`VMEM_STRB_W-1:0]      strb;
   } axil_req_t;

endpackage

//--- hdl/vmem_settings.svh
`ifndef VMEM_SETTINGS_SVH
`define VMEM_SETTINGS_SVH

// AXI4 master side
`define VMEM_ADDR_W      32
`define VMEM_DATA_W      32
`define VMEM_STRB_W      4
`define VMEM_XFER_W      32   // Byte count of one command

// One full burst moves a 64-byte block
`define VMEM_BURST_LEN   16

// AXI-Lite register map
`define VMEM_AXIL_ADDR_W 4
`define VMEM_REG_CTRL    4'h0 // Bit 0 is ce
`define VMEM_REG_BASE    4'h4 // DDR base address
`define VMEM_REG_STATUS  4'h8 // Bit 0 read busy, bit 1 write busy

`endif
